//--- kat_ten_gb_eth.f
source/tge_pkg.sv
source/tge_cfg_regs.sv
source/tge_tx.sv
source/tge_rx.sv
source/tge_led_stretch.sv
source/kat_ten_gb_eth.sv
tb/tb_kat_ten_gb_eth.sv

//--- tb/tge_input.txt
# w addr data readback | t dest_ip dest_port words base | a credits_on | c cycles | x | d | s | l | e
# r dst_mac ethertype dst_ip dst_port src_ip src_port words base good accept(0 no, 1 yes, 2 overrun)
w 1 2c3d4e5f 2c3d4e5f
w 2 1234aa1b 0000aa1b
w 3 c0a80005 c0a80005
w 4 00011f90 00001f90
w 0 1 1
t 0a000001 1388 4 1000
t 0a000002 1389 1 2000
t 0a000003 138a 20 3000
x
a 1
r aa1b2c3d4e5f 0800 c0a80005 1f90 0a000009 4000 5 5000 1 1
r ffffffffffff 0800 c0a80005 1f90 0a00000a 4001 3 5100 1 1
r aa1b2c3d4e50 0800 c0a80005 1f90 0a00000b 4002 3 5200 1 0
r aa1b2c3d4e5f 0806 c0a80005 1f90 0a00000b 4002 3 5300 1 0
r aa1b2c3d4e5f 0800 c0a80006 1f90 0a00000b 4002 3 5400 1 0
r aa1b2c3d4e5f 0800 c0a80005 1f91 0a00000b 4002 3 5500 1 0
r aa1b2c3d4e5f 0800 c0a80005 1f90 0a00000b 4002 3 5600 0 0
r aa1b2c3d4e5f 0800 c0a80005 1f90 0a00000c 4003 2 5700 1 1
d
w 0 0 0
r aa1b2c3d4e5f 0800 c0a80005 1f90 0a00000d 4004 3 5800 1 0
w 0 1 1
r ffffffffffff 0800 c0a80005 1f90 0a00000e 4005 4 5900 1 1
d
a 0
r aa1b2c3d4e5f 0800 c0a80005 1f90 0a00000f 4006 46 6000 1 2
r aa1b2c3d4e5f 0800 c0a80005 1f90 0a000010 4007 3 6100 1 1
a 1
d
a 0
r aa1b2c3d4e5f 0800 c0a80005 1f90 0a000011 4008 3 6200 1 1
w 0 0 0
t 0a000004 138b 5 7000
s
w 0 1 1
a 1
c 30
t 0a000005 138c 6 8000
x
l
e

//--- tb/tb_kat_ten_gb_eth.sv
`timescale 1ns/1ps
module tb_kat_ten_gb_eth;

  localparam int TX_DEPTH = 64;

  logic        mac_clk;
  logic        mac_resetRR;
  logic        tx_valid;
  logic        tx_end_of_frame;
  logic [63:0] tx_data;
  logic [31:0] tx_dest_ip;
  logic [15:0] tx_dest_port;
  logic        tx_credit;
  logic        tx_overflow;
  logic        rx_valid;
  logic        rx_end_of_frame;
  logic [63:0] rx_data;
  logic [31:0] rx_source_ip;
  logic [15:0] rx_source_port;
  logic        rx_overrun;
  logic        rx_overrun_ack;
  logic        rx_credit;
  logic [63:0] mac_tx_data;
  logic [7:0]  mac_tx_data_valid;
  logic        mac_tx_start;
  logic        mac_tx_ack;
  logic [63:0] mac_rx_data;
  logic [7:0]  mac_rx_data_valid;
  logic        mac_rx_good_frame;
  logic        mac_rx_bad_frame;
  logic        cfg_wr_en;
  logic [3:0]  cfg_addr;
  logic [31:0] cfg_wr_data;
  logic [31:0] cfg_rd_data;
  logic [7:0]  xaui_status;
  logic        led_up;
  logic        led_rx;
  logic        led_tx;

  integer       seed = 56;
  int           cycles = 0;
  int           limit = 0;
  bit           checks_on = 0;
  bit           auto_credit = 0;
  int           tx_credits = TX_DEPTH;
  int           rx_credits = 0;
  int           tx_since = 1000;
  int           rx_since = 1000;
  logic [31:0]  local_ip = '0;
  logic [15:0]  local_port = '0;
  logic [63:0]  tx_exp[$];
  int           tx_len[$];
  logic [112:0] rx_exp[$];

  kat_ten_gb_eth #(
    .TX_DEPTH  (TX_DEPTH),
    .RX_DEPTH  (64),
    .LED_WIDTH (4)
  ) i_kat_ten_gb_eth (.*);

  initial mac_clk = 1'b0;
  always #4 mac_clk = ~mac_clk;

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "stopping on first error");
  endtask

  task automatic value_error(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    stop_run();
  endtask

  // Run length guard
  always @(posedge mac_clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles > limit) begin
      $display("Timeout: the run went past %0d cycles without finishing", limit);
      stop_run();
    end
  end

  // Cycles since each LED event, as seen on the clock edge
  always @(posedge mac_clk) begin
    tx_since <= mac_tx_start ? 0 : (tx_since < 1000 ? tx_since + 1 : tx_since);
    rx_since <= mac_rx_good_frame ? 0 : (rx_since < 1000 ? rx_since + 1 : rx_since);
  end

  always @(negedge mac_clk) begin
    if (checks_on) begin
      assert (!tx_overflow) else value_error("tx_overflow pulsed with every word within credits");
      if (tx_since >= 3 && tx_since <= 15) begin
        assert (led_tx == 1'b1) else value_error("led_tx low after tx event");
      end
      if (tx_since >= 19) begin
        assert (led_tx == 1'b0) else value_error("led_tx still high");
      end
      if (rx_since >= 3 && rx_since <= 15) begin
        assert (led_rx == 1'b1) else value_error("led_rx low after rx event");
      end
      if (rx_since >= 19) begin
        assert (led_rx == 1'b0) else value_error("led_rx still high");
      end
    end
  end

  // Application rx side checker and rx credits at random times
  always @(negedge mac_clk) begin
    if (checks_on && rx_valid) begin
      assert (rx_credits > 0) else value_error("rx word delivered without a credit");
      rx_credits--;
      if (rx_exp.size() == 0) begin
        value_error($sformatf("unexpected rx word %h", rx_data));
      end else begin
        assert ({rx_data, rx_end_of_frame, rx_source_ip, rx_source_port} == rx_exp[0])
          else value_error($sformatf("rx word %h eof %b ip %h port %h, expected %h",
                                     rx_data, rx_end_of_frame, rx_source_ip,
                                     rx_source_port, rx_exp[0]));
        void'(rx_exp.pop_front());
      end
    end
    // A new credit only counts for words after this edge
    rx_credit = 1'b0;
    if (auto_credit && ($random(seed) & 3) == 0) begin
      rx_credit = 1'b1;
      rx_credits++;
    end
  end

  task automatic check_tx_word(input logic [63:0] w);
    if (tx_exp.size() == 0) begin
      value_error($sformatf("unexpected MAC tx word %h", w));
    end else begin
      assert (w == tx_exp[0])
        else value_error($sformatf("MAC tx word %h, expected %h", w, tx_exp[0]));
      void'(tx_exp.pop_front());
    end
  endtask

  // MAC model, acks start after a random delay and collects the frame
  always @(negedge mac_clk) begin : mac_model
    static int state = 0;
    static int delay = 0;
    static int got = 0;
    if (tx_credit) begin
      tx_credits++;
      assert (tx_credits <= TX_DEPTH) else value_error("more tx credits than buffer words");
    end
    case (state)
      0: begin
        if (mac_tx_start) begin
          assert (mac_tx_data_valid == 8'hff) else value_error("start without valid bytes");
          check_tx_word(mac_tx_data);
          got = 1;
          delay = $random(seed) & 7;
          state = 1;
        end
      end
      1: begin
        if (delay == 0) begin
          mac_tx_ack = 1'b1;
          state = 2;
        end else begin
          delay--;
        end
      end
      2: begin
        mac_tx_ack = 1'b0;
        assert (!mac_tx_start) else value_error("mac_tx_start held after ack");
        check_tx_word(mac_tx_data);
        got++;
        state = 3;
      end
      default: begin
        if (mac_tx_data_valid != 8'd0) begin
          check_tx_word(mac_tx_data);
          got++;
        end else begin
          if (tx_len.size() == 0) begin
            value_error("MAC tx frame with no frame expected");
          end else begin
            assert (got == tx_len[0])
              else value_error($sformatf("MAC tx frame of %0d words, expected %0d",
                                         got, tx_len[0]));
            void'(tx_len.pop_front());
          end
          state = 0;
        end
      end
    endcase
  end

  task automatic cfg_write(input logic [3:0] addr, input logic [31:0] data,
                           input logic [31:0] exp_rd);
    @(negedge mac_clk);
    cfg_wr_en   = 1'b1;
    cfg_addr    = addr;
    cfg_wr_data = data;
    @(negedge mac_clk);
    cfg_wr_en = 1'b0;
    @(negedge mac_clk);
    assert (cfg_rd_data == exp_rd)
      else value_error($sformatf("register %0d reads %h, expected %h", addr, cfg_rd_data, exp_rd));
    if (addr == 4'd3) local_ip = data;
    if (addr == 4'd4) local_port = data[15:0];
  endtask

  task automatic send_tx(input logic [31:0] ip, input logic [15:0] port, input int n,
                         input logic [63:0] base);
    tx_exp.push_back({48'hffff_ffff_ffff, 16'h0800});
    tx_exp.push_back({local_ip, ip});
    tx_exp.push_back({local_port, port, 16'(n), 16'h0000});
    for (int i = 0; i < n; i++) begin
      tx_exp.push_back(base + i);
    end
    tx_len.push_back(n + 3);
    for (int i = 0; i < n; i++) begin
      @(negedge mac_clk);
      while (tx_credits == 0) @(negedge mac_clk);
      tx_valid        = 1'b1;
      tx_data         = base + i;
      tx_end_of_frame = (i == n - 1);
      tx_dest_ip      = ip;
      tx_dest_port    = port;
      tx_credits--;
    end
    @(negedge mac_clk);
    tx_valid        = 1'b0;
    tx_end_of_frame = 1'b0;
  endtask

  task automatic send_rx(input logic [47:0] dmac, input logic [15:0] etype,
                         input logic [31:0] dip, input logic [15:0] dport,
                         input logic [31:0] sip, input logic [15:0] sport, input int n,
                         input logic [63:0] base, input bit good, input int acc);
    logic [63:0] words[$];
    words.push_back({dmac, etype});
    words.push_back({sip, dip});
    words.push_back({sport, dport, 16'(n), 16'h0000});
    for (int i = 0; i < n; i++) begin
      words.push_back(base + i);
      if (acc == 1) rx_exp.push_back({base + i, i == n - 1, sip, sport});
    end
    foreach (words[k]) begin
      @(negedge mac_clk);
      mac_rx_data       = words[k];
      mac_rx_data_valid = 8'hff;
    end
    @(negedge mac_clk);
    mac_rx_data       = '0;
    mac_rx_data_valid = 8'd0;
    mac_rx_good_frame = good;
    mac_rx_bad_frame  = !good;
    @(negedge mac_clk);
    mac_rx_good_frame = 1'b0;
    mac_rx_bad_frame  = 1'b0;
    if (acc == 2) begin
      assert (rx_overrun) else value_error("rx_overrun not set by oversize frame");
      rx_overrun_ack = 1'b1;
      @(negedge mac_clk);
      rx_overrun_ack = 1'b0;
      @(negedge mac_clk);
      assert (!rx_overrun) else value_error("rx_overrun not cleared by ack");
    end else begin
      assert (!rx_overrun) else value_error("rx_overrun set unexpectedly");
    end
  endtask

  task automatic apply_soft_reset();
    auto_credit <= 1'b0;
    repeat (2) @(negedge mac_clk);
    cfg_write(4'd0, 32'd2, 32'd0);
    repeat (3) @(negedge mac_clk);
    tx_exp.delete();
    tx_len.delete();
    rx_exp.delete();
    rx_credits = 0;
    tx_credits = TX_DEPTH;
  endtask

  task automatic check_link_led();
    @(negedge mac_clk);
    xaui_status = 8'h00;
    repeat (3) @(negedge mac_clk);
    assert (!led_up) else value_error("led_up high while link is down");
    xaui_status = 8'hfc;
    repeat (20) @(negedge mac_clk);
    assert (led_up) else value_error("led_up low after link came back");
  endtask

  initial begin : run
    int fd;
    int nlines;
    int code;
    string cmd;
    string line;
    logic [63:0] a[10];
    tx_valid          = 1'b0;
    tx_end_of_frame   = 1'b0;
    tx_data           = '0;
    tx_dest_ip        = '0;
    tx_dest_port      = '0;
    rx_overrun_ack    = 1'b0;
    rx_credit         = 1'b0;
    mac_tx_ack        = 1'b0;
    mac_rx_data       = '0;
    mac_rx_data_valid = '0;
    mac_rx_good_frame = 1'b0;
    mac_rx_bad_frame  = 1'b0;
    cfg_wr_en         = 1'b0;
    cfg_addr          = '0;
    cfg_wr_data       = '0;
    xaui_status       = 8'hfc;
    mac_resetRR       = 1'b1;
    fd = $fopen("tb/tge_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file tb/tge_input.txt");
      stop_run();
    end
    nlines = 0;
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      nlines++;
    end
    $fclose(fd);
    limit = 64 * nlines + 2000;
    fd = $fopen("tb/tge_input.txt", "r");
    repeat (3) @(posedge mac_clk);
    @(negedge mac_clk);
    mac_resetRR = 1'b0;
    checks_on = 1;
    while ($fscanf(fd, "%s", cmd) == 1) begin
      if (cmd[0] == "#") begin
        code = $fgets(line, fd);
      end else if (cmd == "w") begin
        code = $fscanf(fd, "%h %h %h", a[0], a[1], a[2]);
        cfg_write(a[0][3:0], a[1][31:0], a[2][31:0]);
      end else if (cmd == "t") begin
        code = $fscanf(fd, "%h %h %h %h", a[0], a[1], a[2], a[3]);
        send_tx(a[0][31:0], a[1][15:0], int'(a[2]), a[3]);
      end else if (cmd == "r") begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h",
                       a[0], a[1], a[2], a[3], a[4], a[5], a[6], a[7], a[8], a[9]);
        send_rx(a[0][47:0], a[1][15:0], a[2][31:0], a[3][15:0], a[4][31:0], a[5][15:0],
                int'(a[6]), a[7], a[8][0], int'(a[9]));
      end else if (cmd == "a") begin
        code = $fscanf(fd, "%h", a[0]);
        @(negedge mac_clk);
        auto_credit <= a[0][0];
      end else if (cmd == "c") begin
        code = $fscanf(fd, "%h", a[0]);
        repeat (int'(a[0])) @(negedge mac_clk);
      end else if (cmd == "x") begin
        while (tx_exp.size() != 0 || tx_credits != TX_DEPTH) @(negedge mac_clk);
      end else if (cmd == "d") begin
        while (rx_exp.size() != 0) @(negedge mac_clk);
      end else if (cmd == "s") begin
        apply_soft_reset();
      end else if (cmd == "l") begin
        check_link_led();
      end else if (cmd == "e") begin
        break;
      end else begin
        $display("Unknown command %s in the stimulus file", cmd);
        stop_run();
      end
    end
    $fclose(fd);
    repeat (20) @(negedge mac_clk);
    assert (tx_exp.size() == 0) else value_error("MAC tx words still missing");
    assert (rx_exp.size() == 0) else value_error("rx words still missing");
    assert (tx_credits == TX_DEPTH) else value_error("tx credits not all returned");
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- source/kat_ten_gb_eth.sv
`timescale 1ns/1ps
module kat_ten_gb_eth
  import tge_pkg::*;
#(
  parameter int TX_DEPTH  = 64,
  parameter int RX_DEPTH  = 64,
  parameter int LED_WIDTH = 26
) (
  input  logic        mac_clk,
  input  logic        mac_resetRR,
  // Application tx
  input  logic        tx_valid,
  input  logic        tx_end_of_frame,
  input  logic [63:0] tx_data,
  input  logic [31:0] tx_dest_ip,
  input  logic [15:0] tx_dest_port,
  output logic        tx_credit,
  output logic        tx_overflow,
  // Application rx
  output logic        rx_valid,
  output logic        rx_end_of_frame,
  output logic [63:0] rx_data,
  output logic [31:0] rx_source_ip,
  output logic [15:0] rx_source_port,
  output logic        rx_overrun,
  input  logic        rx_overrun_ack,
  input  logic        rx_credit,
  // MAC side
  output logic [63:0] mac_tx_data,
  output logic [7:0]  mac_tx_data_valid,
  output logic        mac_tx_start,
  input  logic        mac_tx_ack,
  input  logic [63:0] mac_rx_data,
  input  logic [7:0]  mac_rx_data_valid,
  input  logic        mac_rx_good_frame,
  input  logic        mac_rx_bad_frame,
  // Register port
  input  logic        cfg_wr_en,
  input  logic [3:0]  cfg_addr,
  input  logic [31:0] cfg_wr_data,
  output logic [31:0] cfg_rd_data,
  // Status
  input  logic [7:0]  xaui_status,
  output logic        led_up,
  output logic        led_rx,
  output logic        led_tx
);

  local_cfg_t local_cfg;
  logic       soft_reset;

  tge_cfg_regs i_tge_cfg_regs (
    .mac_clk     (mac_clk),
    .mac_resetRR (mac_resetRR),
    .cfg_wr_en   (cfg_wr_en),
    .cfg_addr    (cfg_addr),
    .cfg_wr_data (cfg_wr_data),
    .cfg_rd_data (cfg_rd_data),
    .local_cfg   (local_cfg),
    .soft_reset  (soft_reset)
  );

  tge_tx #(
    .TX_DEPTH (TX_DEPTH)
  ) i_tge_tx (
    .mac_clk           (mac_clk),
    .mac_resetRR       (mac_resetRR),
    .soft_reset        (soft_reset),
    .local_cfg         (local_cfg),
    .tx_valid          (tx_valid),
    .tx_end_of_frame   (tx_end_of_frame),
    .tx_data           (tx_data),
    .tx_dest_ip        (tx_dest_ip),
    .tx_dest_port      (tx_dest_port),
    .mac_tx_ack        (mac_tx_ack),
    .tx_credit         (tx_credit),
    .tx_overflow       (tx_overflow),
    .mac_tx_data       (mac_tx_data),
    .mac_tx_data_valid (mac_tx_data_valid),
    .mac_tx_start      (mac_tx_start)
  );

  tge_rx #(
    .RX_DEPTH (RX_DEPTH)
  ) i_tge_rx (
    .mac_clk           (mac_clk),
    .mac_resetRR       (mac_resetRR),
    .soft_reset        (soft_reset),
    .local_cfg         (local_cfg),
    .mac_rx_data       (mac_rx_data),
    .mac_rx_data_valid (mac_rx_data_valid),
    .mac_rx_good_frame (mac_rx_good_frame),
    .mac_rx_bad_frame  (mac_rx_bad_frame),
    .rx_credit         (rx_credit),
    .rx_overrun_ack    (rx_overrun_ack),
    .rx_valid          (rx_valid),
    .rx_end_of_frame   (rx_end_of_frame),
    .rx_data           (rx_data),
    .rx_source_ip      (rx_source_ip),
    .rx_source_port    (rx_source_port),
    .rx_overrun        (rx_overrun)
  );

  tge_led_stretch #(
    .LED_WIDTH (LED_WIDTH)
  ) i_tge_led_stretch (
    .mac_clk           (mac_clk),
    .mac_resetRR       (mac_resetRR),
    .xaui_status       (xaui_status),
    .mac_tx_start      (mac_tx_start),
    .mac_rx_good_frame (mac_rx_good_frame),
    .led_up            (led_up),
    .led_rx            (led_rx),
    .led_tx            (led_tx)
  );

endmodule

//--- source/tge_led_stretch.sv
`timescale 1ns/1ps
module tge_led_stretch #(
  parameter int LED_WIDTH = 26
) (
  input  logic       mac_clk,
  input  logic       mac_resetRR,
  input  logic [7:0] xaui_status,
  input  logic       mac_tx_start,
  input  logic       mac_rx_good_frame,
  output logic       led_up,
  output logic       led_rx,
  output logic       led_tx
);

  logic [LED_WIDTH-1:0] down_cnt;
  logic [LED_WIDTH-1:0] rx_cnt;
  logic [LED_WIDTH-1:0] tx_cnt;
  logic                 link_down;

  // All five lane status bits must be set for link up
  assign link_down = xaui_status[6:2] != 5'b11111;

  always_ff @(posedge mac_clk) begin
    if (mac_resetRR) begin
      down_cnt <= '0;
      rx_cnt   <= '0;
      tx_cnt   <= '0;
    end else begin
      if (link_down) begin
        down_cnt <= '1;
      end else if (down_cnt != '0) begin
        down_cnt <= down_cnt - 1'b1;
      end
      if (mac_rx_good_frame) begin
        rx_cnt <= '1;
      end else if (rx_cnt != '0) begin
        rx_cnt <= rx_cnt - 1'b1;
      end
      if (mac_tx_start) begin
        tx_cnt <= '1;
      end else if (tx_cnt != '0) begin
        tx_cnt <= tx_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_resetRR) begin
      led_up <= 1'b0;
      led_rx <= 1'b0;
      led_tx <= 1'b0;
    end else begin
      led_up <= down_cnt == '0;
      led_rx <= rx_cnt != '0;
      led_tx <= tx_cnt != '0;
    end
  end

endmodule

//--- source/tge_rx.sv
`timescale 1ns/1ps
module tge_rx
  import tge_pkg::*;
#(
  parameter int RX_DEPTH = 64
) (
  input  logic        mac_clk,
  input  logic        mac_resetRR,
  input  logic        soft_reset,
  input  local_cfg_t  local_cfg,
  input  logic [63:0] mac_rx_data,
  input  logic [7:0]  mac_rx_data_valid,
  input  logic        mac_rx_good_frame,
  input  logic        mac_rx_bad_frame,
  input  logic        rx_credit,
  input  logic        rx_overrun_ack,
  output logic        rx_valid,
  output logic        rx_end_of_frame,
  output logic [63:0] rx_data,
  output logic [31:0] rx_source_ip,
  output logic [15:0] rx_source_port,
  output logic        rx_overrun
);

  localparam int AW = $clog2(RX_DEPTH);
  localparam logic [AW:0] DEPTH_PTR = (AW + 1)'(RX_DEPTH);

  rx_entry_t     buf_mem [RX_DEPTH];
  logic [AW:0]   wr_ptr;
  logic [AW:0]   spec_ptr;
  logic [AW:0]   rd_ptr;
  logic [AW-1:0] last_idx;
  logic [1:0]    word_idx;
  logic          hdr_ok;
  logic          frm_drop;
  logic [31:0]   src_ip;
  logic [15:0]   src_port;
  logic [63:0]   last_data;
  logic [15:0]   credits;
  hdr_word_u     rx_word;
  logic          word_in;
  logic          keep;
  logic          store;
  logic          spill;
  logic          accept;
  logic          deliver;
  rx_entry_t     out_entry;

  assign rx_word  = mac_rx_data;
  assign word_in  = |mac_rx_data_valid;
  assign last_idx = spec_ptr[AW-1:0] - 1'b1;

  // Payload of a matching frame, stored while space lasts
  assign keep    = word_in && word_idx == HDR_WORDS && hdr_ok && local_cfg.enable && !frm_drop;
  assign store   = keep && (spec_ptr - rd_ptr) != DEPTH_PTR;
  assign spill   = keep && (spec_ptr - rd_ptr) == DEPTH_PTR;
  assign accept  = mac_rx_good_frame && word_idx == HDR_WORDS && hdr_ok && local_cfg.enable &&
                   !frm_drop && spec_ptr != wr_ptr;
  assign deliver = credits != 16'd0 && rd_ptr != wr_ptr;

  // Entries go in unmarked, last one is rewritten with eof on commit
  always_ff @(posedge mac_clk) begin
    if (store) begin
      buf_mem[spec_ptr[AW-1:0]] <= '{data: mac_rx_data, eof: 1'b0,
                                     src_ip: src_ip, src_port: src_port};
      last_data <= mac_rx_data;
    end else if (accept) begin
      buf_mem[last_idx] <= '{data: last_data, eof: 1'b1,
                             src_ip: src_ip, src_port: src_port};
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_resetRR || soft_reset) begin
      wr_ptr     <= '0;
      spec_ptr   <= '0;
      word_idx   <= 2'd0;
      hdr_ok     <= 1'b0;
      frm_drop   <= 1'b0;
      src_ip     <= 32'd0;
      src_port   <= 16'd0;
      rx_overrun <= 1'b0;
    end else begin
      if (word_in) begin
        case (word_idx)
          2'd0: begin
            hdr_ok <= (rx_word.eth.dst_mac == local_cfg.mac ||
                       rx_word.eth.dst_mac == BCAST_MAC) &&
                      rx_word.eth.ethertype == ETHERTYPE_IP;
          end
          2'd1: begin
            hdr_ok <= hdr_ok && rx_word.ip.dst_ip == local_cfg.ip;
            src_ip <= rx_word.ip.src_ip;
          end
          2'd2: begin
            hdr_ok   <= hdr_ok && rx_word.udp.dst_port == local_cfg.port;
            src_port <= rx_word.udp.src_port;
          end
          default: begin
          end
        endcase
        if (word_idx != HDR_WORDS) begin
          word_idx <= word_idx + 2'd1;
        end
      end

      if (store) begin
        spec_ptr <= spec_ptr + 1'b1;
      end
      if (spill) begin
        frm_drop <= 1'b1;
      end

      // Commit or roll back at the frame end pulse
      if (mac_rx_good_frame || mac_rx_bad_frame) begin
        word_idx <= 2'd0;
        frm_drop <= 1'b0;
        if (accept) begin
          wr_ptr <= spec_ptr;
        end else begin
          spec_ptr <= wr_ptr;
        end
      end

      if (rx_overrun_ack) begin
        rx_overrun <= 1'b0;
      end
      if (spill) begin
        rx_overrun <= 1'b1;
      end
    end
  end

  // Credit gated read side
  always_ff @(posedge mac_clk) begin
    if (mac_resetRR || soft_reset) begin
      rd_ptr   <= '0;
      credits  <= 16'd0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= deliver;
      credits  <= credits + 16'(rx_credit) - 16'(deliver);
      if (deliver) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge mac_clk) begin
    if (deliver) begin
      out_entry <= buf_mem[rd_ptr[AW-1:0]];
    end
  end

  assign rx_data         = out_entry.data;
  assign rx_end_of_frame = out_entry.eof;
  assign rx_source_ip    = out_entry.src_ip;
  assign rx_source_port  = out_entry.src_port;

endmodule

//--- source/tge_tx.sv
`timescale 1ns/1ps
module tge_tx
  import tge_pkg::*;
#(
  parameter int TX_DEPTH = 64
) (
  input  logic        mac_clk,
  input  logic        mac_resetRR,
  input  logic        soft_reset,
  input  local_cfg_t  local_cfg,
  input  logic        tx_valid,
  input  logic        tx_end_of_frame,
  input  logic [63:0] tx_data,
  input  logic [31:0] tx_dest_ip,
  input  logic [15:0] tx_dest_port,
  input  logic        mac_tx_ack,
  output logic        tx_credit,
  output logic        tx_overflow,
  output logic [63:0] mac_tx_data,
  output logic [7:0]  mac_tx_data_valid,
  output logic        mac_tx_start
);

  // TX_DEPTH is a power of two, pointers carry one extra wrap bit
  localparam int AW = $clog2(TX_DEPTH);
  localparam logic [AW:0] DEPTH_PTR = (AW + 1)'(TX_DEPTH);

  typedef struct packed {
    logic [15:0] len;
    logic [31:0] ip;
    logic [15:0] port;
  } tx_frame_t;

  typedef enum logic [2:0] {S_IDLE, S_START, S_HDR1, S_HDR2, S_DATA} tx_state_t;

  logic [63:0] data_mem [TX_DEPTH];
  tx_frame_t   frm_mem  [TX_DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic [AW:0] frm_wr;
  logic [AW:0] frm_rd;
  logic [15:0] in_len;
  logic [15:0] frm_len;
  logic [15:0] remaining;
  tx_frame_t   cur_frm;
  tx_state_t   state;
  logic        buf_full;
  logic        wr_accept;
  logic        rd_word;
  logic [63:0] rd_data;
  hdr_word_u   hdr0;
  hdr_word_u   hdr1;
  hdr_word_u   hdr2;

  assign buf_full  = (wr_ptr - rd_ptr) == DEPTH_PTR;
  assign wr_accept = tx_valid && !buf_full;
  assign frm_len   = in_len + 16'(wr_accept);
  assign rd_word   = (state == S_HDR2) || (state == S_DATA && remaining != 16'd0);
  assign rd_data   = data_mem[rd_ptr[AW-1:0]];

  // Header words for the frame at the head of the queue
  always_comb begin
    hdr0.eth.dst_mac   = BCAST_MAC;
    hdr0.eth.ethertype = ETHERTYPE_IP;
    hdr1.ip.src_ip     = local_cfg.ip;
    hdr1.ip.dst_ip     = cur_frm.ip;
    hdr2.udp.src_port  = local_cfg.port;
    hdr2.udp.dst_port  = cur_frm.port;
    hdr2.udp.length    = cur_frm.len;
    hdr2.udp.checksum  = 16'd0;
  end

  // Payload store and per frame record
  always_ff @(posedge mac_clk) begin
    if (wr_accept) begin
      data_mem[wr_ptr[AW-1:0]] <= tx_data;
    end
    if (tx_valid && tx_end_of_frame) begin
      frm_mem[frm_wr[AW-1:0]] <= '{len: frm_len, ip: tx_dest_ip, port: tx_dest_port};
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_resetRR || soft_reset) begin
      wr_ptr            <= '0;
      rd_ptr            <= '0;
      frm_wr            <= '0;
      frm_rd            <= '0;
      in_len            <= 16'd0;
      remaining         <= 16'd0;
      cur_frm           <= '0;
      state             <= S_IDLE;
      tx_credit         <= 1'b0;
      tx_overflow       <= 1'b0;
      mac_tx_start      <= 1'b0;
      mac_tx_data       <= 64'd0;
      mac_tx_data_valid <= 8'd0;
    end else begin
      tx_overflow <= tx_valid && buf_full;
      tx_credit   <= rd_word;

      if (wr_accept) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // Frames with every word dropped never get a record
      if (tx_valid) begin
        if (tx_end_of_frame) begin
          in_len <= 16'd0;
          if (frm_len != 16'd0) begin
            frm_wr <= frm_wr + 1'b1;
          end
        end else begin
          in_len <= frm_len;
        end
      end

      case (state)
        S_IDLE: begin
          if (frm_wr != frm_rd && local_cfg.enable) begin
            cur_frm           <= frm_mem[frm_rd[AW-1:0]];
            frm_rd            <= frm_rd + 1'b1;
            mac_tx_start      <= 1'b1;
            mac_tx_data       <= hdr0.raw;
            mac_tx_data_valid <= 8'hff;
            state             <= S_START;
          end
        end
        S_START: begin
          if (mac_tx_ack) begin
            mac_tx_start <= 1'b0;
            mac_tx_data  <= hdr1.raw;
            state        <= S_HDR1;
          end
        end
        S_HDR1: begin
          mac_tx_data <= hdr2.raw;
          state       <= S_HDR2;
        end
        S_HDR2: begin
          remaining <= cur_frm.len - 16'd1;
          state     <= S_DATA;
        end
        S_DATA: begin
          if (remaining != 16'd0) begin
            remaining <= remaining - 16'd1;
          end else begin
            mac_tx_data_valid <= 8'd0;
            state             <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase

      // Payload word out, one credit back per word
      if (rd_word) begin
        rd_ptr      <= rd_ptr + 1'b1;
        mac_tx_data <= rd_data;
      end
    end
  end

endmodule

//--- source/tge_cfg_regs.sv
`timescale 1ns/1ps
module tge_cfg_regs
  import tge_pkg::*;
(
  input  logic        mac_clk,
  input  logic        mac_resetRR,
  input  logic        cfg_wr_en,
  input  logic [3:0]  cfg_addr,
  input  logic [31:0] cfg_wr_data,
  output logic [31:0] cfg_rd_data,
  output local_cfg_t  local_cfg,
  output logic        soft_reset
);

  logic [31:0] rd_mux;

  // Register writes, soft reset bit is self clearing
  always_ff @(posedge mac_clk) begin
    if (mac_resetRR) begin
      local_cfg  <= '0;
      soft_reset <= 1'b0;
    end else begin
      soft_reset <= 1'b0;
      if (cfg_wr_en) begin
        case (cfg_addr)
          CFG_ADDR_CTRL: begin
            local_cfg.enable <= cfg_wr_data[0];
            soft_reset       <= cfg_wr_data[1];
          end
          CFG_ADDR_MAC_LO: begin
            local_cfg.mac[31:0] <= cfg_wr_data;
          end
          CFG_ADDR_MAC_HI: begin
            local_cfg.mac[47:32] <= cfg_wr_data[15:0];
          end
          CFG_ADDR_IP: begin
            local_cfg.ip <= cfg_wr_data;
          end
          CFG_ADDR_PORT: begin
            local_cfg.port <= cfg_wr_data[15:0];
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Readback select
  always_comb begin
    case (cfg_addr)
      CFG_ADDR_CTRL:   rd_mux = {31'd0, local_cfg.enable};
      CFG_ADDR_MAC_LO: rd_mux = local_cfg.mac[31:0];
      CFG_ADDR_MAC_HI: rd_mux = {16'd0, local_cfg.mac[47:32]};
      CFG_ADDR_IP:     rd_mux = local_cfg.ip;
      CFG_ADDR_PORT:   rd_mux = {16'd0, local_cfg.port};
      default:         rd_mux = 32'd0;
    endcase
  end

  // One cycle read latency
  always_ff @(posedge mac_clk) begin
    cfg_rd_data <= rd_mux;
  end

endmodule

//--- source/tge_pkg.sv
package tge_pkg;

  // Local station settings, written through the config port
  typedef struct packed {
    logic        enable;
    logic [47:0] mac;
    logic [31:0] ip;
    logic [15:0] port;
  } local_cfg_t;

  // Header word 0
  typedef struct packed {
    logic [47:0] dst_mac;
    logic [15:0] ethertype;
  } eth_hdr_t;

  // Header word 1
  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
  } ip_hdr_t;

  // Header word 2, length counts 64-bit payload words
  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
    logic [15:0] checksum;
  } udp_hdr_t;

  // One MAC word, meaning depends on its position in the frame
  typedef union packed {
    logic [63:0] raw;
    eth_hdr_t    eth;
    ip_hdr_t     ip;
    udp_hdr_t    udp;
  } hdr_word_u;

  // Rx buffer entry
  typedef struct packed {
    logic [63:0] data;
    logic        eof;
    logic [31:0] src_ip;
    logic [15:0] src_port;
  } rx_entry_t;

  localparam logic [15:0] ETHERTYPE_IP = 16'h0800;
  localparam logic [47:0] BCAST_MAC    = 48'hffff_ffff_ffff;
  localparam logic [1:0]  HDR_WORDS    = 2'd3;

  // Register map
  localparam logic [3:0] CFG_ADDR_CTRL   = 4'd0;
  localparam logic [3:0] CFG_ADDR_MAC_LO = 4'd1;
  localparam logic [3:0] CFG_ADDR_MAC_HI = 4'd2;
  localparam logic [3:0] CFG_ADDR_IP     = 4'd3;
  localparam logic [3:0] CFG_ADDR_PORT   = 4'd4;

endpackage
